/* dv/phy_rx_top_chk.sv */
// Receive top output assertions
`default_nettype none

module phy_rx_top_chk (
    input logic                        CLK,
    input logic                        nRST,
    input logic                        flit_valid,
    input logic                        err,
    input phy_types_pkg::comma_sel_t   comma_sel,
    input chiplet_types_pkg::pkt_len_t remaining_flits
);

    timeunit 1ns;
    timeprecision 1ps;

    a_known: assert property (@(posedge CLK) disable iff (!nRST)
        !$isunknown({err, flit_valid}))
        else $error("err or flit_valid is unknown after reset");

    a_err_with_valid: assert property (@(posedge CLK) disable iff (!nRST)
        err |-> flit_valid)
        else $error("err is high without flit_valid");

    // only a header flit loads the counter upward.
    a_rem_rise: assert property (@(posedge CLK) disable iff (!nRST)
        (remaining_flits > $past(remaining_flits)) |->
            (flit_valid && comma_sel == phy_types_pkg::DATA_SEL))
        else $error("remaining_flits rose outside a data flit");

endmodule

bind phy_rx_top phy_rx_top_chk u_chk (
    .CLK             (CLK),
    .nRST            (nRST),
    .flit_valid      (flit_valid),
    .err             (err),
    .comma_sel       (comma_sel),
    .remaining_flits (remaining_flits)
);

`default_nettype wire

/* dv/tb_clk_gen.sv */
// Testbench clock and reset
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic CLK,
    output logic nRST
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;
    end

endmodule

`default_nettype wire

/* dv/enc_8b10b_model.svh */
// 8b/10b encoder and framer model
`ifndef ENC_8B10B_MODEL_SVH
`define ENC_8B10B_MODEL_SVH

// 5b/6b and 3b/4b codes for negative running disparity in abcdei and fghj order.
localparam logic [5:0] CODE6_NEG [32] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
};
localparam logic [3:0] CODE4_NEG [8] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
};
// fghj of K28.y after 001111. The whole symbol is inverted at positive disparity.
localparam logic [3:0] K28_FGHJ [8] = '{
    4'b0100, 4'b1001, 4'b0101, 4'b0011, 4'b0010, 4'b1010, 4'b0110, 4'b1000
};

typedef enum logic [1:0] {
    M_WAIT_START,
    M_WAIT_HEADER,
    M_IN_PACKET
} model_state_t;

model_state_t                m_state = M_WAIT_START;
logic [FLIT_W-1:0]           m_flit  = '0;
phy_types_pkg::comma_sel_t   m_sel   = phy_types_pkg::START_SEL;
chiplet_types_pkg::pkt_len_t m_rem   = '0;
logic                        enc_rd [NUM_LANES] = '{default: 1'b0};

function automatic phy_types_pkg::sym10_t encode_lane(input int lane,
                                                      input phy_types_pkg::byte8_t b,
                                                      input logic k);
    logic [5:0] c6;
    logic [3:0] c4;
    logic       rd;
    logic       rd_mid;
    rd = enc_rd[lane];
    if (k) begin
        c6 = rd ? 6'b110000 : 6'b001111;
        c4 = rd ? ~K28_FGHJ[b[7:5]] : K28_FGHJ[b[7:5]];
    end else begin
        c6 = CODE6_NEG[b[4:0]];
        if (rd && ($countones(c6) != 3 || b[4:0] == 5'd7)) begin
            c6 = ~c6;
        end
        rd_mid = rd ^ ($countones(c6) != 3);
        c4 = CODE4_NEG[b[7:5]];
        // alternate D.x.7 avoids a run of five equal bits.
        if (b[7:5] == 3'd7 &&
            ((!rd_mid && (b[4:0] == 5'd17 || b[4:0] == 5'd18 || b[4:0] == 5'd20)) ||
             (rd_mid && (b[4:0] == 5'd11 || b[4:0] == 5'd13 || b[4:0] == 5'd14)))) begin
            c4 = 4'b0111;
        end
        if (rd_mid && ($countones(c4) != 2 || b[7:5] == 3'd3)) begin
            c4 = ~c4;
        end
    end
    enc_rd[lane] = rd ^ ($countones(c6) != 3) ^ ($countones(c4) != 2);
    return {c6, c4};
endfunction

function automatic expect_t model_word(input logic                      valid,
                                       input phy_types_pkg::word_kind_t kind,
                                       input logic [FLIT_W-1:0]         bytes,
                                       input logic [NUM_LANES-1:0]      kflags,
                                       input logic                      code_bad);
    expect_t                   e;
    phy_types_pkg::comma_sel_t sel;
    logic                      unknown;
    logic                      k_bad;
    logic                      order_bad;
    sel       = phy_types_pkg::DATA_SEL;
    unknown   = 1'b0;
    k_bad     = 1'b0;
    order_bad = 1'b0;
    if (kind == phy_types_pkg::KIND_COMMA_1) begin
        unknown = !kflags[0];
        case (bytes[7:0])
            phy_types_pkg::K28_1: sel = phy_types_pkg::START_SEL;
            phy_types_pkg::K28_2: sel = phy_types_pkg::END_SEL;
            phy_types_pkg::K28_3: sel = phy_types_pkg::GRTCRED0_SEL;
            phy_types_pkg::K28_4: sel = phy_types_pkg::GRTCRED1_SEL;
            default:              unknown = 1'b1;
        endcase
    end else if (kind == phy_types_pkg::KIND_COMMA_2) begin
        sel     = phy_types_pkg::ACK_SEL;
        unknown = !(kflags[1] && bytes[15:8] == phy_types_pkg::K28_5);
        k_bad   = kflags[0];
    end else begin
        k_bad = |kflags;
    end
    if (valid && !code_bad && !unknown) begin
        m_sel = sel;
        if (sel == phy_types_pkg::DATA_SEL) begin
            m_flit = bytes;
        end else if (sel == phy_types_pkg::ACK_SEL) begin
            m_flit[7:0] = bytes[7:0];
        end
        case (m_state)
            M_WAIT_START: begin
                order_bad = (sel == phy_types_pkg::DATA_SEL);
                if (sel == phy_types_pkg::START_SEL) begin
                    m_state = M_WAIT_HEADER;
                end
            end
            M_WAIT_HEADER: begin
                order_bad = (sel == phy_types_pkg::START_SEL || sel == phy_types_pkg::END_SEL);
                if (sel == phy_types_pkg::DATA_SEL) begin
                    m_rem   = bytes[chiplet_types_pkg::HDR_LEN_LSB +:
                                    chiplet_types_pkg::PKT_LENGTH_WIDTH];
                    m_state = M_IN_PACKET;
                end
            end
            default: begin
                if (sel == phy_types_pkg::DATA_SEL) begin
                    order_bad = (m_rem == '0);
                    if (!order_bad) begin
                        m_rem = chiplet_types_pkg::pkt_len_t'(m_rem - 1);
                    end
                end else if (sel == phy_types_pkg::END_SEL || sel == phy_types_pkg::START_SEL) begin
                    order_bad = (sel == phy_types_pkg::START_SEL) || (m_rem != '0);
                    m_rem     = '0;
                    m_state   = (sel == phy_types_pkg::END_SEL) ? M_WAIT_START : M_WAIT_HEADER;
                end
            end
        endcase
    end
    e.valid = valid;
    e.err   = valid & (code_bad | unknown | k_bad | order_bad);
    e.flit  = m_flit;
    e.sel   = m_sel;
    e.rem   = m_rem;
    return e;
endfunction

`endif

/* dv/tb_phy_rx_top.sv */
// PHY receive testbench
`default_nettype none

module tb_phy_rx_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_LANES  = 5;
    localparam int FLIT_W     = NUM_LANES * 8;
    localparam int PERIOD_NS  = 8;
    localparam int NUM_CYCLES = 3000;
    localparam int TIMEOUT_NS = (NUM_CYCLES + 5 + 2 + 4) * PERIOD_NS + 200;

    // word choices of the generator.
    localparam int W_START = 0;
    localparam int W_END   = 1;
    localparam int W_DATA  = 2;
    localparam int W_GRT0  = 3;
    localparam int W_ACK   = 5;
    localparam int W_BADK  = 6;

    localparam logic [2:0] BAD_Y [4] = '{3'd0, 3'd5, 3'd6, 3'd7};

    typedef struct packed {
        logic                        valid;
        logic                        err;
        logic [FLIT_W-1:0]           flit;
        phy_types_pkg::comma_sel_t   sel;
        chiplet_types_pkg::pkt_len_t rem;
    } expect_t;

    logic                        CLK;
    logic                        nRST;
    logic [NUM_LANES*10-1:0]     enc_word;
    phy_types_pkg::word_kind_t   word_kind;
    logic                        in_valid;
    logic [FLIT_W-1:0]           flit;
    logic                        flit_valid;
    phy_types_pkg::comma_sel_t   comma_sel;
    chiplet_types_pkg::pkt_len_t remaining_flits;
    logic                        err;

    int                          seed = 32'hc6ce_6221;
    int                          fail_count = 0;
    expect_t                     exp_q[$];
    phy_types_pkg::word_kind_t   cur_kind;
    logic [FLIT_W-1:0]           cur_bytes;
    logic [NUM_LANES-1:0]        cur_kflags;

    `include "enc_8b10b_model.svh"

    tb_clk_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(5)) u_clk_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    phy_rx_top #(.NUM_LANES(NUM_LANES)) dut (
        .CLK             (CLK),
        .nRST            (nRST),
        .enc_word        (enc_word),
        .word_kind       (word_kind),
        .in_valid        (in_valid),
        .flit            (flit),
        .flit_valid      (flit_valid),
        .comma_sel       (comma_sel),
        .remaining_flits (remaining_flits),
        .err             (err)
    );

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            fail_count++;
            $display("FAIL at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "output mismatch on %s", name);
        end
    endtask

    task automatic compare_outputs(input expect_t e);
        check_value("flit_valid", 64'(e.valid), 64'(flit_valid));
        check_value("err", 64'(e.err), 64'(err));
        check_value("flit", 64'(e.flit), 64'(flit));
        check_value("comma_sel", 64'(e.sel), 64'(comma_sel));
        check_value("remaining_flits", 64'(e.rem), 64'(remaining_flits));
    endtask

    // the legal word that the current packet state asks for.
    function automatic int next_legal();
        if (m_state == M_WAIT_START) begin
            return W_START;
        end
        if (m_state == M_WAIT_HEADER || m_rem != '0) begin
            return W_DATA;
        end
        return W_END;
    endfunction

    task automatic fill_word(input int choice);
        phy_types_pkg::byte8_t kb;
        for (int i = 0; i < NUM_LANES; i++) begin
            cur_bytes[i*8 +: 8] = 8'($random(seed));
        end
        cur_kind   = phy_types_pkg::KIND_COMMA_1;
        cur_kflags = '0;
        cur_kflags[0] = 1'b1;
        case (choice)
            W_START: kb = phy_types_pkg::K28_1;
            W_END:   kb = phy_types_pkg::K28_2;
            W_GRT0:  kb = phy_types_pkg::K28_3;
            4:       kb = phy_types_pkg::K28_4;
            W_BADK:  kb = {BAD_Y[2'($random(seed))], 5'd28};
            default: kb = cur_bytes[7:0];
        endcase
        cur_bytes[7:0] = kb;
        if (choice == W_ACK) begin
            cur_kind        = phy_types_pkg::KIND_COMMA_2;
            cur_kflags      = '0;
            cur_kflags[1]   = 1'b1;
            cur_bytes[15:8] = phy_types_pkg::K28_5;
        end else if (choice == W_DATA) begin
            cur_kind   = phy_types_pkg::KIND_DATA;
            cur_kflags = '0;
        end
    endtask

    task automatic drive_idle();
        for (int i = 0; i < NUM_LANES; i++) begin
            enc_word[i*10 +: 10] = 10'($random(seed));
        end
        in_valid = 1'b0;
        exp_q.push_back(model_word(1'b0, phy_types_pkg::KIND_DATA, '0, '0, 1'b0));
    endtask

    task automatic drive_cycle();
        int r;
        int choice;
        int lanes_used;
        int zero_lane;
        r = int'({$random(seed)} % 64);
        if (r < 6) begin
            drive_idle();
        end else begin
            if (r < 12) begin
                choice = W_GRT0 + int'({$random(seed)} % 3);
            end else if (r < 16) begin
                choice = int'({$random(seed)} % 3);
            end else if (r < 19) begin
                choice = W_BADK;
            end else begin
                choice = next_legal();
            end
            fill_word(choice);
            lanes_used = (cur_kind == phy_types_pkg::KIND_DATA) ? NUM_LANES :
                         ((cur_kind == phy_types_pkg::KIND_COMMA_2) ? 2 : 1);
            zero_lane = -1;
            if ({$random(seed)} % 32 == 0) begin
                zero_lane = int'({$random(seed)} % lanes_used);
            end
            // lanes outside the word's enables carry garbage.
            for (int i = 0; i < NUM_LANES; i++) begin
                if (i == zero_lane) begin
                    enc_word[i*10 +: 10] = '0;
                end else if (i < lanes_used) begin
                    enc_word[i*10 +: 10] = encode_lane(i, cur_bytes[i*8 +: 8], cur_kflags[i]);
                end else begin
                    enc_word[i*10 +: 10] = 10'($random(seed));
                end
            end
            word_kind = cur_kind;
            in_valid  = 1'b1;
            exp_q.push_back(model_word(1'b1, cur_kind, cur_bytes, cur_kflags, zero_lane >= 0));
        end
    endtask

    initial begin
        enc_word  = '0;
        word_kind = phy_types_pkg::KIND_DATA;
        in_valid  = 1'b0;
        wait (nRST === 1'b1);
        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(posedge CLK);
            #1;
            if (n < 4) begin
                drive_idle();
            end else begin
                drive_cycle();
            end
            @(negedge CLK);
            if (exp_q.size() > 2) begin
                compare_outputs(exp_q.pop_front());
            end
        end
        // two words are still in flight.
        repeat (2) begin
            @(posedge CLK);
            #1;
            drive_idle();
            @(negedge CLK);
            compare_outputs(exp_q.pop_front());
        end
        if (fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* phy_rx_top.f */
+incdir+dv
rtl/phy_types_pkg.sv
rtl/chiplet_types_pkg.sv
rtl/rx_lane_if.sv
rtl/rx_word_capture.sv
rtl/dec_8b10b.sv
rtl/rx_flit_framer.sv
rtl/phy_rx_top.sv
dv/tb_clk_gen.sv
dv/phy_rx_top_chk.sv
dv/tb_phy_rx_top.sv

/* rtl/chiplet_types_pkg.sv */
// Chiplet packet types
`default_nettype none

package chiplet_types_pkg;

    // width of the packet length field and of the flit counter.
    localparam int PKT_LENGTH_WIDTH = 4;

    typedef logic [PKT_LENGTH_WIDTH-1:0] pkt_len_t;

    // the length field sits in byte 0 of the header flit.
    localparam int HDR_LEN_LSB = 0;

    // ack metadata layout inside byte 0.
    localparam int ACK_VC_BIT  = 7;
    localparam int ACK_ID_MSB  = 6;
    localparam int ACK_ID_LSB  = 5;
    localparam int ACK_REQ_MSB = 4;
    localparam int ACK_REQ_LSB = 0;

endpackage

`default_nettype wire

/* rtl/dec_8b10b.sv */
// 8b/10b lane decoder
`default_nettype none

module dec_8b10b (
    input  logic                  CLK,
    input  logic                  nRST,
    input  phy_types_pkg::sym10_t sym,
    input  logic                  en,
    output phy_types_pkg::byte8_t data,
    output logic                  is_k,
    output logic                  code_err
);

    logic [5:0] abcdei;
    logic [3:0] fghj;
    logic [3:0] fghj_dec;
    logic [4:0] edcba;
    logic [2:0] hgf;
    logic [2:0] ones6;
    logic [2:0] ones4;
    logic       bad6;
    logic       bad4;
    logic       flip6;
    logic       flip4;
    logic       disp_err;
    logic       rd;
    logic       rd_mid;
    logic       rd_next;

    assign abcdei = sym[9:4];
    assign fghj   = sym[3:0];

    assign is_k = (abcdei == 6'b001111) || (abcdei == 6'b110000);

    // K28 with positive disparity is the full complement, including fghj.
    assign fghj_dec = (abcdei == 6'b110000) ? ~fghj : fghj;

    always_comb begin
        case (abcdei)
            6'b100111, 6'b011000: edcba = 5'd0;
            6'b011101, 6'b100010: edcba = 5'd1;
            6'b101101, 6'b010010: edcba = 5'd2;
            6'b110001:            edcba = 5'd3;
            6'b110101, 6'b001010: edcba = 5'd4;
            6'b101001:            edcba = 5'd5;
            6'b011001:            edcba = 5'd6;
            6'b111000, 6'b000111: edcba = 5'd7;
            6'b111001, 6'b000110: edcba = 5'd8;
            6'b100101:            edcba = 5'd9;
            6'b010101:            edcba = 5'd10;
            6'b110100:            edcba = 5'd11;
            6'b001101:            edcba = 5'd12;
            6'b101100:            edcba = 5'd13;
            6'b011100:            edcba = 5'd14;
            6'b010111, 6'b101000: edcba = 5'd15;
            6'b011011, 6'b100100: edcba = 5'd16;
            6'b100011:            edcba = 5'd17;
            6'b010011:            edcba = 5'd18;
            6'b110010:            edcba = 5'd19;
            6'b001011:            edcba = 5'd20;
            6'b101010:            edcba = 5'd21;
            6'b011010:            edcba = 5'd22;
            6'b111010, 6'b000101: edcba = 5'd23;
            6'b110011, 6'b001100: edcba = 5'd24;
            6'b100110:            edcba = 5'd25;
            6'b010110:            edcba = 5'd26;
            6'b110110, 6'b001001: edcba = 5'd27;
            6'b001110:            edcba = 5'd28;
            6'b101110, 6'b010001: edcba = 5'd29;
            6'b011110, 6'b100001: edcba = 5'd30;
            6'b101011, 6'b010100: edcba = 5'd31;
            6'b001111, 6'b110000: edcba = 5'd28;
            default:              edcba = 5'd0;
        endcase
    end

    always_comb begin
        case (fghj_dec)
            4'b1011, 4'b0100:                   hgf = 3'd0;
            4'b1001:                            hgf = 3'd1;
            4'b0101:                            hgf = 3'd2;
            4'b1100, 4'b0011:                   hgf = 3'd3;
            4'b1101, 4'b0010:                   hgf = 3'd4;
            4'b1010:                            hgf = 3'd5;
            4'b0110:                            hgf = 3'd6;
            4'b1110, 4'b0001, 4'b0111, 4'b1000: hgf = 3'd7;
            default:                            hgf = 3'd0;
        endcase
    end

    assign data = {hgf, edcba};

    assign ones6 = 3'($countones(abcdei));
    assign ones4 = 3'($countones(fghj));

    // every balanced 6b and every 4b pattern of weight 1..3 is in use.
    assign bad6 = (ones6 < 3'd2) || (ones6 > 3'd4) ||
                  (abcdei == 6'b111100) || (abcdei == 6'b000011);
    assign bad4 = (ones4 == 3'd0) || (ones4 == 3'd4);

    // rd is 1 for positive running disparity.
    assign flip6   = (ones6 != 3'd3);
    assign flip4   = (ones4 != 3'd2);
    assign rd_mid  = rd ^ flip6;
    assign rd_next = rd_mid ^ flip4;

    assign disp_err = (flip6 && ((ones6 > 3'd3) == rd)) ||
                      ((abcdei == 6'b111000) && rd) ||
                      ((abcdei == 6'b000111) && !rd) ||
                      (flip4 && ((ones4 > 3'd2) == rd_mid)) ||
                      ((fghj == 4'b1100) && rd_mid) ||
                      ((fghj == 4'b0011) && !rd_mid);

    assign code_err = en & (bad6 | bad4 | disp_err);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rd <= 1'b0;
        end else if (en && !bad6 && !bad4) begin
            rd <= rd_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/phy_rx_top.sv */
// PHY receive top level
`default_nettype none

module phy_rx_top #(
    parameter int NUM_LANES = 5
) (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic [NUM_LANES*10-1:0]     enc_word,
    input  phy_types_pkg::word_kind_t   word_kind,
    input  logic                        in_valid,
    output logic [NUM_LANES*8-1:0]      flit,
    output logic                        flit_valid,
    output phy_types_pkg::comma_sel_t   comma_sel,
    output chiplet_types_pkg::pkt_len_t remaining_flits,
    output logic                        err
);

    rx_lane_if #(.NUM_LANES(NUM_LANES)) lanes ();

    rx_word_capture #(.NUM_LANES(NUM_LANES)) u_capture (
        .CLK       (CLK),
        .nRST      (nRST),
        .enc_word  (enc_word),
        .word_kind (word_kind),
        .in_valid  (in_valid),
        .lanes     (lanes.capture)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        dec_8b10b u_dec (
            .CLK      (CLK),
            .nRST     (nRST),
            .sym      (lanes.sym[i]),
            .en       (lanes.lane_en[i]),
            .data     (lanes.data[i]),
            .is_k     (lanes.is_k[i]),
            .code_err (lanes.code_err[i])
        );
    end

    rx_flit_framer #(.NUM_LANES(NUM_LANES)) u_framer (
        .CLK             (CLK),
        .nRST            (nRST),
        .lanes           (lanes.framer),
        .flit            (flit),
        .flit_valid      (flit_valid),
        .err             (err),
        .comma_sel       (comma_sel),
        .remaining_flits (remaining_flits)
    );

endmodule

`default_nettype wire

/* rtl/phy_types_pkg.sv */
// PHY symbol and comma types
`default_nettype none

package phy_types_pkg;

    // one code group with abcdei in bits 9:4 and fghj in bits 3:0.
    typedef logic [9:0] sym10_t;

    // decoded byte with HGF in bits 7:5 and EDCBA in bits 4:0.
    typedef logic [7:0] byte8_t;

    // kind of each word, as supplied by the link layer.
    typedef enum logic [1:0] {
        KIND_COMMA_1 = 2'd0,
        KIND_COMMA_2 = 2'd1,
        KIND_DATA    = 2'd2
    } word_kind_t;

    // classification of the last accepted word.
    typedef enum logic [2:0] {
        START_SEL    = 3'd0,
        END_SEL      = 3'd1,
        GRTCRED0_SEL = 3'd2,
        GRTCRED1_SEL = 3'd3,
        ACK_SEL      = 3'd4,
        DATA_SEL     = 3'd5
    } comma_sel_t;

    // K28.y control bytes carry y in the upper three bits.
    localparam byte8_t K28_1 = 8'h3C;
    localparam byte8_t K28_2 = 8'h5C;
    localparam byte8_t K28_3 = 8'h7C;
    localparam byte8_t K28_4 = 8'h9C;
    localparam byte8_t K28_5 = 8'hBC;

endpackage

`default_nettype wire

/* rtl/rx_flit_framer.sv */
// Flit framer and packet order check
`default_nettype none

module rx_flit_framer #(
    parameter int NUM_LANES = 5
) (
    input  logic                        CLK,
    input  logic                        nRST,
    rx_lane_if.framer                   lanes,
    output logic [NUM_LANES*8-1:0]      flit,
    output logic                        flit_valid,
    output logic                        err,
    output phy_types_pkg::comma_sel_t   comma_sel,
    output chiplet_types_pkg::pkt_len_t remaining_flits
);

    typedef enum logic [1:0] {
        WAIT_START,
        WAIT_HEADER,
        IN_PACKET
    } frame_state_t;

    frame_state_t                state, n_state;
    logic [NUM_LANES*8-1:0]      word_bytes;
    logic [NUM_LANES*8-1:0]      n_flit;
    phy_types_pkg::comma_sel_t   word_sel, n_sel;
    chiplet_types_pkg::pkt_len_t n_rem;
    chiplet_types_pkg::pkt_len_t hdr_len;
    phy_types_pkg::byte8_t       ack_byte;
    logic                        code_err_any;
    logic                        k_any;
    logic                        k_err;
    logic                        unknown;
    logic                        order_err;
    logic                        drop;

    always_comb begin
        code_err_any = 1'b0;
        k_any        = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            word_bytes[i*8 +: 8] = lanes.data[i];
            code_err_any = code_err_any | (lanes.code_err[i] & lanes.lane_en[i]);
            k_any        = k_any | (lanes.is_k[i] & lanes.lane_en[i]);
        end
    end

    assign hdr_len = word_bytes[chiplet_types_pkg::HDR_LEN_LSB +:
                                chiplet_types_pkg::PKT_LENGTH_WIDTH];

    always_comb begin
        ack_byte = '0;
        ack_byte[chiplet_types_pkg::ACK_VC_BIT] = lanes.data[0][chiplet_types_pkg::ACK_VC_BIT];
        ack_byte[chiplet_types_pkg::ACK_ID_MSB:chiplet_types_pkg::ACK_ID_LSB] =
            lanes.data[0][chiplet_types_pkg::ACK_ID_MSB:chiplet_types_pkg::ACK_ID_LSB];
        ack_byte[chiplet_types_pkg::ACK_REQ_MSB:chiplet_types_pkg::ACK_REQ_LSB] =
            lanes.data[0][chiplet_types_pkg::ACK_REQ_MSB:chiplet_types_pkg::ACK_REQ_LSB];
    end

    always_comb begin
        word_sel = phy_types_pkg::DATA_SEL;
        unknown  = 1'b0;
        k_err    = 1'b0;
        case (lanes.kind)
            phy_types_pkg::KIND_COMMA_1: begin
                case ({lanes.is_k[0], lanes.data[0]})
                    {1'b1, phy_types_pkg::K28_1}: word_sel = phy_types_pkg::START_SEL;
                    {1'b1, phy_types_pkg::K28_2}: word_sel = phy_types_pkg::END_SEL;
                    {1'b1, phy_types_pkg::K28_3}: word_sel = phy_types_pkg::GRTCRED0_SEL;
                    {1'b1, phy_types_pkg::K28_4}: word_sel = phy_types_pkg::GRTCRED1_SEL;
                    default:                      unknown = 1'b1;
                endcase
            end
            phy_types_pkg::KIND_COMMA_2: begin
                // lane 0 carries the ack metadata and must be a data byte.
                word_sel = phy_types_pkg::ACK_SEL;
                unknown  = !(lanes.is_k[1] && (lanes.data[1] == phy_types_pkg::K28_5));
                k_err    = lanes.is_k[0];
            end
            phy_types_pkg::KIND_DATA: begin
                k_err = k_any;
            end
            default: unknown = 1'b1;
        endcase
    end

    assign drop = code_err_any | unknown;

    always_comb begin
        n_flit    = flit;
        n_sel     = comma_sel;
        n_state   = state;
        n_rem     = remaining_flits;
        order_err = 1'b0;
        if (lanes.valid && !drop) begin
            n_sel = word_sel;
            if (word_sel == phy_types_pkg::DATA_SEL) begin
                n_flit = word_bytes;
            end else if (word_sel == phy_types_pkg::ACK_SEL) begin
                n_flit[7:0] = ack_byte;
            end
            case (state)
                WAIT_START: begin
                    if (word_sel == phy_types_pkg::START_SEL) begin
                        n_state = WAIT_HEADER;
                    end else if (word_sel == phy_types_pkg::DATA_SEL) begin
                        order_err = 1'b1;
                    end
                end
                WAIT_HEADER: begin
                    if (word_sel == phy_types_pkg::DATA_SEL) begin
                        n_rem   = hdr_len;
                        n_state = IN_PACKET;
                    end else if (word_sel == phy_types_pkg::START_SEL ||
                                 word_sel == phy_types_pkg::END_SEL) begin
                        order_err = 1'b1;
                    end
                end
                IN_PACKET: begin
                    if (word_sel == phy_types_pkg::DATA_SEL) begin
                        if (remaining_flits == '0) begin
                            order_err = 1'b1;
                        end else begin
                            n_rem = remaining_flits - 1'b1;
                        end
                    end else if (word_sel == phy_types_pkg::END_SEL) begin
                        order_err = (remaining_flits != '0);
                        n_rem     = '0;
                        n_state   = WAIT_START;
                    end else if (word_sel == phy_types_pkg::START_SEL) begin
                        order_err = 1'b1;
                        n_rem     = '0;
                        n_state   = WAIT_HEADER;
                    end
                end
                default: n_state = WAIT_START;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state           <= WAIT_START;
            flit            <= '0;
            flit_valid      <= 1'b0;
            err             <= 1'b0;
            comma_sel       <= phy_types_pkg::START_SEL;
            remaining_flits <= '0;
        end else begin
            state           <= n_state;
            flit            <= n_flit;
            flit_valid      <= lanes.valid;
            err             <= lanes.valid & (drop | k_err | order_err);
            comma_sel       <= n_sel;
            remaining_flits <= n_rem;
        end
    end

endmodule

`default_nettype wire

/* rtl/rx_lane_if.sv */
// Receive lane bundle
`default_nettype none

interface rx_lane_if #(
    parameter int NUM_LANES = 5
);

    phy_types_pkg::sym10_t     sym      [NUM_LANES];
    logic                      lane_en  [NUM_LANES];
    phy_types_pkg::word_kind_t kind;
    logic                      valid;

    // driven per lane by the decoders.
    phy_types_pkg::byte8_t     data     [NUM_LANES];
    logic                      is_k     [NUM_LANES];
    logic                      code_err [NUM_LANES];

    modport capture (
        output sym, lane_en, kind, valid
    );

    modport framer (
        input kind, valid, lane_en, data, is_k, code_err
    );

endinterface

`default_nettype wire

/* rtl/rx_word_capture.sv */
// Receive word capture
`default_nettype none

module rx_word_capture #(
    parameter int NUM_LANES = 5
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic [NUM_LANES*10-1:0]   enc_word,
    input  phy_types_pkg::word_kind_t word_kind,
    input  logic                      in_valid,
    rx_lane_if.capture                lanes
);

    logic [NUM_LANES-1:0] lane_mask;

    // commas only occupy the low lanes and the rest carry idle garbage.
    always_comb begin
        lane_mask = '0;
        case (word_kind)
            phy_types_pkg::KIND_COMMA_1: lane_mask[0] = 1'b1;
            phy_types_pkg::KIND_COMMA_2: lane_mask[1:0] = 2'b11;
            phy_types_pkg::KIND_DATA:    lane_mask = '1;
            default:                     lane_mask = '0;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lanes.valid <= 1'b0;
            lanes.kind  <= phy_types_pkg::KIND_DATA;
            for (int i = 0; i < NUM_LANES; i++) begin
                lanes.lane_en[i] <= 1'b0;
            end
        end else begin
            lanes.valid <= in_valid;
            if (in_valid) begin
                lanes.kind <= word_kind;
            end
            // enables already include the strobe.
            for (int i = 0; i < NUM_LANES; i++) begin
                lanes.lane_en[i] <= in_valid & lane_mask[i];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (in_valid) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                lanes.sym[i] <= enc_word[i*10 +: 10];
            end
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Builds the receive PHY testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f phy_rx_top.f \
    --top-module tb_phy_rx_top --Mdir obj_dir -o sim_phy_rx_top

./obj_dir/sim_phy_rx_top > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
